// File: core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int INSN_SIZE     = 16;
    localparam int INSN_COUNT    = 16;
    localparam int INSN_PTR_SIZE = 4;

    localparam int REG_SIZE      = 8;
    localparam int REG_COUNT     = 16;
    localparam int REG_PTR_SIZE  = 4;

    localparam int CORE_ID_SIZE  = 2;   // bank select bits
    // low two bits of src_1 sit above the full src_0 value
    localparam int ADDR_SIZE     = REG_SIZE + CORE_ID_SIZE;

    typedef enum logic [3:0] {
        NOP = 4'd0,
        ADD,
        SUB,
        MUL,
        DIV,
        CMPGE,
        RSHIFT,
        LSHIFT,
        AND,
        OR,
        XOR,
        LD,
        SET_CONST,
        ST,
        BNZ,
        READY = 4'd15
    } opcode_e;

    typedef union packed {
        struct packed {
            opcode_e                  opcode;
            logic [REG_PTR_SIZE-1:0]  src_0;
            logic [REG_PTR_SIZE-1:0]  src_1;
            logic [REG_PTR_SIZE-1:0]  src_2;    // dst for alu ops and ld
        } r;
        struct packed {
            opcode_e                  opcode;
            logic [REG_PTR_SIZE-1:0]  dst;
            logic [REG_SIZE-1:0]      value;
        } c;
        struct packed {
            opcode_e                  opcode;
            logic [REG_PTR_SIZE-1:0]  cond;
            logic [INSN_PTR_SIZE-1:0] target;
            logic [INSN_SIZE-4-REG_PTR_SIZE-INSN_PTR_SIZE-1:0] unused;
        } b;
    } insn_t;

endpackage

`default_nettype wire

// File: mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_if;
    import core_pkg::*;

    logic [1:0]           enable;     // 01 load, 10 store, 00 idle
    logic [ADDR_SIZE-1:0] addr;
    logic [REG_SIZE-1:0]  wr_data;
    logic [REG_SIZE-1:0]  rd_data;
    logic                 ready;      // one cycle pulse, access completes

    modport core (output enable, output addr, output wr_data, input rd_data, input ready);
    modport memory (input enable, input addr, input wr_data, output rd_data, output ready);

endinterface

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                              clk,
    input  logic                              clear,
    input  logic                              init_r0,
    input  logic [core_pkg::REG_SIZE-1:0]     init_r0_data,
    input  logic [core_pkg::REG_PTR_SIZE-1:0] rd_ptr_0,
    input  logic [core_pkg::REG_PTR_SIZE-1:0] rd_ptr_1,
    input  logic [core_pkg::REG_PTR_SIZE-1:0] rd_ptr_2,
    output logic [core_pkg::REG_SIZE-1:0]     rd_data_0,
    output logic [core_pkg::REG_SIZE-1:0]     rd_data_1,
    output logic [core_pkg::REG_SIZE-1:0]     rd_data_2,
    input  logic                              wr_en,
    input  logic [core_pkg::REG_PTR_SIZE-1:0] wr_ptr,
    input  logic [core_pkg::REG_SIZE-1:0]     wr_data
);
    import core_pkg::*;

    logic [REG_SIZE-1:0] regs [REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (clear)
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        else if (wr_en)
            regs[wr_ptr] <= wr_data;
        if (init_r0)
            regs[0] <= init_r0_data;    // overrides the clear
    end

    // write-through so decode sees the value written back this cycle
    always_comb
    begin
        rd_data_0 = (wr_en && wr_ptr == rd_ptr_0) ? wr_data : regs[rd_ptr_0];
        rd_data_1 = (wr_en && wr_ptr == rd_ptr_1) ? wr_data : regs[rd_ptr_1];
        rd_data_2 = (wr_en && wr_ptr == rd_ptr_2) ? wr_data : regs[rd_ptr_2];
    end

endmodule

`default_nettype wire

// File: insn_memory.sv
`timescale 1ns/1ps
`default_nettype none

module insn_memory (
    input  logic                                                clk,
    input  logic                                                load,
    input  logic [core_pkg::INSN_COUNT*core_pkg::INSN_SIZE-1:0] insn_data,
    input  logic [core_pkg::INSN_PTR_SIZE-1:0]                  insn_ptr,
    output core_pkg::insn_t                                     insn
);
    import core_pkg::*;

    insn_t slots [INSN_COUNT];

    always_ff @(posedge clk)
    begin
        if (load)
            for (int i = 0; i < INSN_COUNT; i++)
                slots[i] <= insn_t'(insn_data[i*INSN_SIZE +: INSN_SIZE]); // slot 0 in low bits
    end

    assign insn = slots[insn_ptr];

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  core_pkg::opcode_e             opcode,
    input  logic [core_pkg::REG_SIZE-1:0] a,
    input  logic [core_pkg::REG_SIZE-1:0] b,
    output logic [core_pkg::REG_SIZE-1:0] result,
    output logic                          branch_taken
);
    import core_pkg::*;

    always_comb
    begin
        case (opcode)
            ADD:     result = a + b;
            SUB:     result = a - b;
            MUL:     result = a * b;                    // low byte kept
            DIV:     result = (b == '0) ? '0 : a / b;
            CMPGE:   result = REG_SIZE'(a >= b);
            RSHIFT:  result = a >> b[2:0];
            LSHIFT:  result = a << b[2:0];
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            default: result = '0;
        endcase
    end

    assign branch_taken = (a != '0);

endmodule

`default_nettype wire

// File: core_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module core_pipeline #(
    parameter logic [core_pkg::CORE_ID_SIZE-1:0] CORE_ID = '0
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                init_r0_flag,
    input  logic [core_pkg::REG_SIZE-1:0]                       init_r0_data,
    input  logic [core_pkg::INSN_COUNT*core_pkg::INSN_SIZE-1:0] insn_data,
    input  logic                                                start,
    output logic                                                ready,
    mem_if.core                                                 mem
);
    import core_pkg::*;

    localparam insn_t NOP_INSN   = '0;
    localparam insn_t READY_INSN = insn_t'({READY, {(INSN_SIZE - $bits(opcode_e)){1'b0}}});

    function automatic logic is_alu(insn_t i);
        return i.r.opcode inside {ADD, SUB, MUL, DIV, CMPGE, RSHIFT, LSHIFT, AND, OR, XOR};
    endfunction

    function automatic logic writes_reg(insn_t i);
        return is_alu(i) || i.r.opcode == LD || i.r.opcode == SET_CONST;
    endfunction

    function automatic logic [REG_PTR_SIZE-1:0] dst_of(insn_t i);
        return (i.r.opcode == SET_CONST) ? i.c.dst : i.r.src_2;
    endfunction

    function automatic logic is_mem(insn_t i);
        return i.r.opcode == LD || i.r.opcode == ST;
    endfunction

    logic [INSN_PTR_SIZE-1:0]          insn_ptr;
    insn_t                             fd_insn;
    insn_t                             dx_insn;
    insn_t                             xm_insn;
    insn_t                             mw_insn;
    logic [REG_SIZE-1:0]               dx_src_0;
    logic [REG_SIZE-1:0]               dx_src_1;
    logic [REG_SIZE-1:0]               dx_src_2;
    logic [REG_SIZE-1:0]               xm_result;   // src_0 for ld and st
    logic [REG_SIZE-1:0]               xm_src_1;
    logic [REG_SIZE-1:0]               xm_src_2;
    logic [REG_SIZE-1:0]               mw_result;
    logic [REG_SIZE-1:0]               mw_load_data;

    logic                              go;
    logic                              freeze;
    logic                              stall;
    logic                              halt;
    logic                              branch_taken;
    logic                              alu_branch;
    logic [INSN_COUNT*INSN_SIZE-1:0]   program_data;
    insn_t                             im_insn;
    insn_t                             fetch_insn;
    logic [REG_SIZE-1:0]               rd_data_0;
    logic [REG_SIZE-1:0]               rd_data_1;
    logic [REG_SIZE-1:0]               rd_data_2;
    logic                              xm_fwd;
    logic                              mw_fwd;
    logic [REG_PTR_SIZE-1:0]           dx_dst;
    logic [REG_PTR_SIZE-1:0]           xm_dst;
    logic [REG_PTR_SIZE-1:0]           mw_dst;
    logic [REG_SIZE-1:0]               x_src_0;
    logic [REG_SIZE-1:0]               x_src_1;
    logic [REG_SIZE-1:0]               x_src_2;
    logic [REG_SIZE-1:0]               alu_result;
    logic [REG_SIZE-1:0]               x_result;
    logic                              m_ld_fwd;
    logic [REG_SIZE-1:0]               m_src_0;
    logic [REG_SIZE-1:0]               m_src_1;
    logic [REG_SIZE-1:0]               m_src_2;
    logic [REG_SIZE-1:0]               w_result;

    assign go = start && ready;
    assign program_data = reset ? '0 : insn_data;   // reset leaves an all-nop program

    insn_memory u_insn_memory (
        .clk       (clk),
        .load      (reset || go),
        .insn_data (program_data),
        .insn_ptr  (insn_ptr),
        .insn      (im_insn)
    );

    // stop fetching once READY is in flight
    assign halt = fd_insn.r.opcode == READY || dx_insn.r.opcode == READY
               || xm_insn.r.opcode == READY || mw_insn.r.opcode == READY;
    assign fetch_insn = halt ? NOP_INSN
                      : (insn_ptr == INSN_PTR_SIZE'(INSN_COUNT - 1)) ? READY_INSN : im_insn;

    register_file u_register_file (
        .clk          (clk),
        .clear        (reset || go),
        .init_r0      (go && init_r0_flag),
        .init_r0_data (init_r0_data),
        .rd_ptr_0     (fd_insn.r.src_0),
        .rd_ptr_1     (fd_insn.r.src_1),
        .rd_ptr_2     (fd_insn.r.src_2),
        .rd_data_0    (rd_data_0),
        .rd_data_1    (rd_data_1),
        .rd_data_2    (rd_data_2),
        .wr_en        (mw_fwd),
        .wr_ptr       (mw_dst),
        .wr_data      (w_result)
    );

    assign dx_dst = dst_of(dx_insn);
    assign xm_dst = dst_of(xm_insn);
    assign mw_dst = dst_of(mw_insn);
    assign xm_fwd = writes_reg(xm_insn) && xm_insn.r.opcode != LD;  // load data not back yet
    assign mw_fwd = writes_reg(mw_insn);

    // only consumers in execute wait on a load, ld and st pick it up in memory
    assign stall = dx_insn.r.opcode == LD
                && ((is_alu(fd_insn) && (dx_dst == fd_insn.r.src_0 || dx_dst == fd_insn.r.src_1))
                 || (fd_insn.r.opcode == BNZ && dx_dst == fd_insn.b.cond));

    assign x_src_0 = (xm_fwd && xm_dst == dx_insn.r.src_0) ? xm_result
                   : (mw_fwd && mw_dst == dx_insn.r.src_0) ? w_result : dx_src_0;
    assign x_src_1 = (xm_fwd && xm_dst == dx_insn.r.src_1) ? xm_result
                   : (mw_fwd && mw_dst == dx_insn.r.src_1) ? w_result : dx_src_1;
    assign x_src_2 = (xm_fwd && xm_dst == dx_insn.r.src_2) ? xm_result
                   : (mw_fwd && mw_dst == dx_insn.r.src_2) ? w_result : dx_src_2;

    alu u_alu (
        .opcode       (dx_insn.r.opcode),
        .a            (x_src_0),
        .b            (x_src_1),
        .result       (alu_result),
        .branch_taken (alu_branch)
    );

    assign branch_taken = dx_insn.r.opcode == BNZ && alu_branch;

    always_comb
    begin
        if (is_mem(dx_insn))
            x_result = x_src_0;
        else if (dx_insn.r.opcode == SET_CONST)
            x_result = (dx_insn.c.dst == '0) ? REG_SIZE'(CORE_ID) : dx_insn.c.value;
        else
            x_result = alu_result;
    end

    assign m_ld_fwd = mw_insn.r.opcode == LD && is_mem(xm_insn);
    assign m_src_0  = (m_ld_fwd && mw_dst == xm_insn.r.src_0) ? mw_load_data : xm_result;
    assign m_src_1  = (m_ld_fwd && mw_dst == xm_insn.r.src_1) ? mw_load_data : xm_src_1;
    assign m_src_2  = (m_ld_fwd && mw_dst == xm_insn.r.src_2) ? mw_load_data : xm_src_2;

    assign mem.enable  = (xm_insn.r.opcode == LD) ? 2'b01
                       : (xm_insn.r.opcode == ST) ? 2'b10 : 2'b00;
    assign mem.addr    = {m_src_1[CORE_ID_SIZE-1:0], m_src_0};
    assign mem.wr_data = m_src_2;

    assign freeze = ready || (is_mem(xm_insn) && !mem.ready);
    assign w_result = (mw_insn.r.opcode == LD) ? mw_load_data : mw_result;

    always_ff @(posedge clk)
    begin
        if (reset || go)
        begin
            ready    <= 1'b0;
            insn_ptr <= '0;
            fd_insn  <= NOP_INSN;
            dx_insn  <= NOP_INSN;
            xm_insn  <= NOP_INSN;
            mw_insn  <= NOP_INSN;
        end
        else
        begin
            if (mw_insn.r.opcode == READY)
                ready <= 1'b1;
            if (!freeze)
            begin
                mw_insn <= xm_insn;
                xm_insn <= dx_insn;
                if (branch_taken)
                begin
                    insn_ptr <= dx_insn.b.target;
                    dx_insn  <= NOP_INSN;       // flush the two younger ones
                    fd_insn  <= NOP_INSN;
                end
                else if (stall)
                    dx_insn <= NOP_INSN;        // bubble, fetch holds
                else
                begin
                    dx_insn <= fd_insn;
                    fd_insn <= fetch_insn;
                    if (!halt)
                        insn_ptr <= insn_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!freeze)
        begin
            dx_src_0     <= rd_data_0;
            dx_src_1     <= rd_data_1;
            dx_src_2     <= rd_data_2;
            xm_result    <= x_result;
            xm_src_1     <= x_src_1;
            xm_src_2     <= x_src_2;
            mw_result    <= xm_result;
            mw_load_data <= mem.rd_data;
        end
    end

endmodule

`default_nettype wire

// File: data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int MEM_LATENCY = 1
) (
    input  logic                           clk,
    input  logic                           reset,
    mem_if.memory                          mem,
    input  logic [core_pkg::ADDR_SIZE-1:0] host_addr,
    output logic [core_pkg::REG_SIZE-1:0]  host_rd_data
);
    import core_pkg::*;

    localparam int MEM_SIZE = 2 ** ADDR_SIZE;
    localparam int CNT_SIZE = $clog2(MEM_LATENCY + 2);

    logic [REG_SIZE-1:0] data [MEM_SIZE];
    logic [CNT_SIZE-1:0] wait_cnt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wait_cnt <= '0;
            for (int i = 0; i < MEM_SIZE; i++)
                data[i] <= '0;
        end
        else
        begin
            if (mem.ready)
                wait_cnt <= '0;                 // restart for the next request
            else if (mem.enable != 2'b00)
                wait_cnt <= wait_cnt + 1'b1;
            if (mem.ready && mem.enable == 2'b10)
                data[mem.addr] <= mem.wr_data;
        end
    end

    assign mem.ready   = (mem.enable != 2'b00) && (wait_cnt == CNT_SIZE'(MEM_LATENCY));
    assign mem.rd_data = data[mem.addr];
    assign host_rd_data = data[host_addr];     // read-only host port

endmodule

`default_nettype wire

// File: core_system.sv
`timescale 1ns/1ps
`default_nettype none

module core_system #(
    parameter logic [core_pkg::CORE_ID_SIZE-1:0] CORE_ID     = '0,
    parameter int                                MEM_LATENCY = 1
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                start,
    input  logic                                                init_r0_flag,
    input  logic [core_pkg::REG_SIZE-1:0]                       init_r0_data,
    input  logic [core_pkg::INSN_COUNT*core_pkg::INSN_SIZE-1:0] insn_data,
    input  logic [core_pkg::ADDR_SIZE-1:0]                      host_addr,
    output logic                                                ready,
    output logic [core_pkg::REG_SIZE-1:0]                       host_rd_data
);

    mem_if u_mem_if ();

    core_pipeline #(
        .CORE_ID (CORE_ID)
    ) u_core (
        .clk          (clk),
        .reset        (reset),
        .init_r0_flag (init_r0_flag),
        .init_r0_data (init_r0_data),
        .insn_data    (insn_data),
        .start        (start),
        .ready        (ready),
        .mem          (u_mem_if.core)
    );

    data_memory #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_dmem (
        .clk          (clk),
        .reset        (reset),
        .mem          (u_mem_if.memory),
        .host_addr    (host_addr),
        .host_rd_data (host_rd_data)
    );

endmodule

`default_nettype wire

// File: tb_core_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_system;
    import core_pkg::*;

    localparam int CORE_ID         = 2;
    localparam int MEM_LATENCY     = 3;
    localparam int MAX_INSNS       = 64;    // reference gives up on a runaway loop here
    localparam int PROGRAMS        = 7;
    localparam int INSNS_PER_RUN   = 40;    // longest run is the loop with five rounds
    localparam int CYCLES_PER_INSN = 10;    // stall, flush and memory wait together
    localparam int READBACK_CYCLES = 40;
    localparam int TIMEOUT_CYCLES  =
        PROGRAMS * (INSNS_PER_RUN * CYCLES_PER_INSN + READBACK_CYCLES) + 1000;

    logic                            clk;
    logic                            reset;
    logic                            start;
    logic                            init_r0_flag;
    logic [REG_SIZE-1:0]             init_r0_data;
    logic [INSN_COUNT*INSN_SIZE-1:0] insn_data;
    logic [ADDR_SIZE-1:0]            host_addr;
    logic                            ready;
    logic [REG_SIZE-1:0]             host_rd_data;

    logic [INSN_SIZE-1:0]            slots [INSN_COUNT];
    logic [REG_SIZE-1:0]             model_mem [2**ADDR_SIZE];
    logic [ADDR_SIZE-1:0]            store_addrs [$];   // addresses stored by the current test
    int                              check_count;
    int                              error_count;
    int                              test_count;
    int                              checks_at_start;
    int                              errors_at_start;
    int                              cycle_count;
    event                            check_req;
    event                            check_done;

    core_system #(
        .CORE_ID     (CORE_ID),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .init_r0_flag (init_r0_flag),
        .init_r0_data (init_r0_data),
        .insn_data    (insn_data),
        .host_addr    (host_addr),
        .ready        (ready),
        .host_rd_data (host_rd_data)
    );

    initial
        clk = 1'b0;

    always #5 clk = ~clk;

    function automatic logic [INSN_SIZE-1:0] rtype(opcode_e op, logic [3:0] s0,
                                                   logic [3:0] s1, logic [3:0] s2);
        return {op, s0, s1, s2};
    endfunction

    function automatic logic [INSN_SIZE-1:0] set_const(logic [3:0] r, logic [7:0] value);
        return {SET_CONST, r, value};
    endfunction

    function automatic logic [INSN_SIZE-1:0] bnz(logic [3:0] cond, logic [3:0] target);
        return {BNZ, cond, target, 4'h0};
    endfunction

    function automatic logic [INSN_COUNT*INSN_SIZE-1:0] pack_slots();
        logic [INSN_COUNT*INSN_SIZE-1:0] p;

        for (int i = 0; i < INSN_COUNT; i++)
            p[i*INSN_SIZE +: INSN_SIZE] = slots[i];
        return p;
    endfunction

    // ISA model that steps one instruction at a time on its own registers and model_mem
    function automatic void run_program(input logic [INSN_COUNT*INSN_SIZE-1:0] prog,
                                        input logic init_flag,
                                        input logic [REG_SIZE-1:0] init_data);
        logic [REG_SIZE-1:0]  regs [REG_COUNT];
        logic [REG_SIZE-1:0]  a;
        logic [REG_SIZE-1:0]  b;
        logic [ADDR_SIZE-1:0] addr;
        insn_t                insn;
        int                   pc;
        int                   executed;
        bit                   done;

        for (int i = 0; i < REG_COUNT; i++)
            regs[i] = '0;
        if (init_flag)
            regs[0] = init_data;
        pc       = 0;
        executed = 0;
        done     = 1'b0;
        while (!done && executed < MAX_INSNS)
        begin
            insn = prog[pc*INSN_SIZE +: INSN_SIZE];
            if (pc == INSN_COUNT - 1)
                insn.r.opcode = READY;          // last slot always ends the program
            a    = regs[insn.r.src_0];
            b    = regs[insn.r.src_1];
            addr = {b[1:0], a};
            executed++;
            pc++;
            case (insn.r.opcode)
                ADD:       regs[insn.r.src_2] = a + b;
                SUB:       regs[insn.r.src_2] = a - b;
                MUL:       regs[insn.r.src_2] = a * b;
                DIV:       regs[insn.r.src_2] = (b == 0) ? 8'd0 : a / b;
                CMPGE:     regs[insn.r.src_2] = (a >= b) ? 8'd1 : 8'd0;
                RSHIFT:    regs[insn.r.src_2] = a >> b[2:0];
                LSHIFT:    regs[insn.r.src_2] = a << b[2:0];
                AND:       regs[insn.r.src_2] = a & b;
                OR:        regs[insn.r.src_2] = a | b;
                XOR:       regs[insn.r.src_2] = a ^ b;
                LD:        regs[insn.r.src_2] = model_mem[addr];
                SET_CONST: regs[insn.c.dst] = (insn.c.dst == 0) ? 8'(CORE_ID) : insn.c.value;
                ST:
                begin
                    model_mem[addr] = regs[insn.r.src_2];
                    store_addrs.push_back(addr);
                end
                BNZ:
                    if (regs[insn.b.cond] != 0)
                        pc = insn.b.target;
                READY:     done = 1'b1;
                default:   ;
            endcase
        end
    endfunction

    task automatic clear_slots();
        for (int i = 0; i < INSN_COUNT; i++)
            slots[i] = rtype(NOP, 4'h0, 4'h0, 4'h0);
    endtask

    task automatic start_program(input logic [INSN_COUNT*INSN_SIZE-1:0] prog,
                                 input logic flag, input logic [REG_SIZE-1:0] data);
        run_program(prog, flag, data);
        @(posedge clk);
        insn_data    <= prog;
        init_r0_flag <= flag;
        init_r0_data <= data;
        start        <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_count++;
        assert (!ready) else
        begin
            $display("[FAIL] %0t ready after start: got %0b, expected 0", $time, ready);
            error_count++;
        end
    endtask

    task automatic wait_ready();
        while (!ready)
            @(negedge clk);
    endtask

    task automatic begin_test();
        test_count++;
        store_addrs.delete();
        checks_at_start = check_count;
        errors_at_start = error_count;
    endtask

    task automatic check_memory(input string name);
        -> check_req;
        @(check_done);
        $display("test %0d %s: %0d checks, %0d errors", test_count, name,
                 check_count - checks_at_start, error_count - errors_at_start);
    endtask

    // reads back every stored address through the host port
    always
    begin
        @(check_req);
        foreach (store_addrs[i])
        begin
            @(posedge clk);
            host_addr <= store_addrs[i];
            @(negedge clk);
            check_count++;
            assert (host_rd_data == model_mem[store_addrs[i]]) else
            begin
                $display("[FAIL] %0t host_rd_data at 0x%03h: got 0x%02h, expected 0x%02h",
                         $time, store_addrs[i], host_rd_data, model_mem[store_addrs[i]]);
                error_count++;
            end
        end
        -> check_done;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, run went past %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        logic [REG_SIZE-1:0]             a;
        logic [REG_SIZE-1:0]             b;
        logic [REG_SIZE-1:0]             c;
        logic [REG_SIZE-1:0]             base;
        logic [INSN_COUNT*INSN_SIZE-1:0] first_prog;
        int                              ready_wait;

        void'($urandom(5));
        check_count  = 0;
        error_count  = 0;
        test_count   = 0;
        reset        <= 1'b1;
        start        <= 1'b0;
        init_r0_flag <= 1'b0;
        init_r0_data <= '0;
        insn_data    <= '0;
        host_addr    <= '0;
        for (int i = 0; i < 2**ADDR_SIZE; i++)
            model_mem[i] = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        ready_wait = 0;
        do
        begin
            @(negedge clk);
            ready_wait++;
        end
        while (!ready);
        check_count++;
        assert (ready_wait <= 21) else
        begin
            $display("ready took %0d cycles to rise after reset", ready_wait);
            error_count++;
        end
        $display("reset: ready rose after %0d cycles", ready_wait);

        // test 1 chains dependent arithmetic and logic back to back
        begin_test();
        a = 8'($urandom_range(255, 0));
        b = 8'($urandom_range(255, 0));
        clear_slots();
        slots[0]  = set_const(1, a);
        slots[1]  = set_const(2, b);
        slots[2]  = rtype(ADD, 1, 2, 3);
        slots[3]  = rtype(SUB, 3, 1, 4);
        slots[4]  = rtype(MUL, 4, 3, 5);
        slots[5]  = rtype(DIV, 5, 2, 6);
        slots[6]  = rtype(DIV, 5, 0, 7);    // r0 is zero here
        slots[7]  = rtype(CMPGE, 6, 4, 8);
        slots[8]  = rtype(ST, 3, 2, 5);
        slots[9]  = rtype(ST, 4, 1, 6);
        slots[10] = rtype(ST, 5, 8, 7);
        slots[11] = rtype(ST, 6, 3, 8);
        slots[12] = rtype(ST, 7, 4, 3);
        slots[13] = rtype(READY, 0, 0, 0);
        start_program(pack_slots(), 1'b0, '0);
        wait_ready();
        clear_slots();
        slots[0]  = set_const(1, a);
        slots[1]  = set_const(2, b);
        slots[2]  = rtype(RSHIFT, 1, 2, 3);
        slots[3]  = rtype(LSHIFT, 1, 3, 4);
        slots[4]  = rtype(AND, 3, 4, 5);
        slots[5]  = rtype(OR, 4, 1, 6);
        slots[6]  = rtype(XOR, 6, 2, 7);
        slots[7]  = rtype(CMPGE, 2, 1, 8);
        slots[8]  = rtype(ST, 3, 2, 4);
        slots[9]  = rtype(ST, 5, 4, 6);
        slots[10] = rtype(ST, 7, 1, 8);
        slots[11] = rtype(ST, 6, 3, 7);
        slots[12] = rtype(READY, 0, 0, 0);
        start_program(pack_slots(), 1'b0, '0);
        wait_ready();
        check_memory("arithmetic chain");

        // test 2 covers the load-use stall and memory-stage forwarding
        begin_test();
        clear_slots();
        slots[0]  = set_const(1, 8'($urandom_range(255, 0)));
        slots[1]  = set_const(2, 8'($urandom_range(255, 0)));
        slots[2]  = set_const(3, 8'($urandom_range(255, 0)));
        slots[3]  = rtype(ST, 1, 3, 2);
        slots[4]  = rtype(LD, 1, 3, 4);
        slots[5]  = rtype(ADD, 4, 2, 5);    // needs the load right away
        slots[6]  = rtype(LD, 1, 3, 6);
        slots[7]  = rtype(ST, 6, 6, 6);     // address and data from the load
        slots[8]  = rtype(ST, 5, 0, 5);
        slots[9]  = rtype(LD, 6, 6, 7);
        slots[10] = rtype(ST, 1, 7, 7);
        slots[11] = rtype(READY, 0, 0, 0);
        start_program(pack_slots(), 1'b0, '0);
        wait_ready();
        check_memory("load-use");

        // test 3 counts a loop down and slot 7 must not run inside it
        begin_test();
        clear_slots();
        slots[0]  = set_const(1, 8'($urandom_range(5, 1)));
        slots[1]  = set_const(2, 8'd1);
        slots[2]  = set_const(3, 8'd0);
        slots[3]  = set_const(4, 8'($urandom_range(255, 0)));
        slots[4]  = rtype(ADD, 3, 1, 3);
        slots[5]  = rtype(SUB, 1, 2, 1);
        slots[6]  = bnz(1, 4);
        slots[7]  = rtype(ADD, 3, 4, 3);
        slots[8]  = set_const(6, 8'($urandom_range(255, 0)));
        slots[9]  = rtype(ST, 6, 2, 3);
        slots[10] = rtype(ST, 4, 0, 1);
        slots[11] = rtype(READY, 0, 0, 0);
        start_program(pack_slots(), 1'b0, '0);
        wait_ready();
        check_memory("loop");

        // test 4 takes R0 from the host and then the core identity
        begin_test();
        c = 8'($urandom_range(255, 0));
        clear_slots();
        slots[0]  = set_const(1, 8'd1);
        slots[1]  = rtype(ADD, 0, 1, 2);
        slots[2]  = rtype(XOR, 0, 2, 3);
        slots[3]  = rtype(ST, 2, 1, 0);
        slots[4]  = rtype(ST, 3, 1, 2);
        slots[5]  = set_const(0, 8'h77);    // value ignored for r0
        slots[6]  = rtype(ADD, 0, 0, 4);
        slots[7]  = set_const(5, 8'($urandom_range(255, 0)));
        slots[8]  = rtype(ST, 5, 0, 0);
        slots[9]  = rtype(ST, 5, 1, 4);
        slots[10] = rtype(READY, 0, 0, 0);
        start_program(pack_slots(), 1'b1, c);
        wait_ready();
        check_memory("identity and init");

        // test 5 ignores start while busy and keeps memory across a second program
        begin_test();
        base = 8'($urandom_range(255, 0));
        a    = 8'($urandom_range(255, 0));
        b    = 8'($urandom_range(255, 0));
        clear_slots();
        slots[0]  = set_const(1, base);
        slots[1]  = set_const(2, a);
        slots[2]  = set_const(3, 8'd3);
        slots[3]  = set_const(5, 8'd1);
        slots[4]  = rtype(ST, 1, 3, 2);
        slots[5]  = rtype(ADD, 1, 5, 4);
        slots[6]  = rtype(ST, 4, 3, 1);
        slots[7]  = rtype(ADD, 4, 5, 6);
        slots[8]  = rtype(ST, 6, 3, 4);
        slots[9]  = rtype(READY, 0, 0, 0);
        first_prog = pack_slots();
        start_program(first_prog, 1'b0, '0);
        clear_slots();
        slots[0]  = set_const(1, base);
        slots[1]  = set_const(2, ~a);
        slots[2]  = set_const(3, 8'd3);
        slots[3]  = rtype(ST, 1, 3, 2);
        slots[4]  = rtype(READY, 0, 0, 0);
        repeat (3) @(posedge clk);
        insn_data <= pack_slots();          // must not be picked up
        start     <= 1'b1;
        @(posedge clk);
        start     <= 1'b0;
        insn_data <= first_prog;
        wait_ready();
        clear_slots();
        slots[0]  = set_const(1, base);
        slots[1]  = set_const(2, b);
        slots[2]  = set_const(3, 8'd3);
        slots[3]  = set_const(5, 8'd1);
        slots[4]  = rtype(ADD, 1, 5, 4);
        slots[5]  = rtype(ST, 4, 3, 2);     // overwrites the middle byte only
        slots[6]  = rtype(READY, 0, 0, 0);
        start_program(pack_slots(), 1'b0, '0);
        wait_ready();
        check_memory("restart");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
core_pkg.sv
mem_if.sv
register_file.sv
insn_memory.sv
alu.sv
core_pipeline.sv
data_memory.sv
core_system.sv
tb_core_system.sv

// File: run.sh
#!/bin/sh
# build and run tb_core_system with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_core_system -Mdir obj_dir -o sim_core
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0
